// ==== hdl/ccPkg.sv ====
`default_nettype none

package ccPkg;

    // Graph geometry
    localparam int numNodes = 16;
    localparam int nodeWidth = $clog2(numNodes);
    localparam int numEdges = numNodes * (numNodes - 1) / 2;

    // Room for every node being its own component
    localparam int countWidth = 6;

    localparam int slotWidth = 16;

    // Upper-triangle adjacency, row-major, top 8 bits unused
    typedef logic [127:0] graphT;

    typedef logic [countWidth-1:0] countT;

    typedef struct packed {
        graphT graph;
        logic [slotWidth-1:0] slot;
    } botEntryT;

    typedef struct packed {
        countT count;
        logic [slotWidth-1:0] slot;
    } resultT;

endpackage

`default_nettype wire

// ==== hdl/slotRam.sv ====
`default_nettype none

module slotRam #(
    parameter int width = 6,
    parameter int addrWidth = 9
) (
    input  wire                 clk,

    input  wire                 writeEnable,
    input  wire [addrWidth-1:0] writeAddr,
    input  wire [width-1:0]     dataIn,

    input  wire [addrWidth-1:0] readAddr,
    output logic [width-1:0]    dataOut
);

    logic [width-1:0] mem [2**addrWidth];

    // Read sees the word from before a same-cycle write
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= dataIn;
        end
        dataOut <= mem[readAddr];
    end

endmodule

`default_nettype wire

// ==== hdl/inputFifo.sv ====
`default_nettype none

module inputFifo #(
    parameter int fifoDepthLog2 = 5
) (
    input  wire                     clk,
    input  wire                     reset,

    input  wire                     writeEnable,
    input  wire ccPkg::botEntryT    dataIn,
    output logic [fifoDepthLog2:0]  usedw,

    input  wire                     readRequest,
    output ccPkg::botEntryT         dataOut,
    output logic                    dataOutValid
);

    localparam int depth = 2**fifoDepthLog2;

    ccPkg::botEntryT mem [depth];

    logic [fifoDepthLog2-1:0] wrPtr;
    logic [fifoDepthLog2-1:0] rdPtr;
    logic [fifoDepthLog2:0]   fill;

    ccPkg::botEntryT readStage;
    logic            readStageValid;

    logic doWrite;
    logic doRead;

    // Requests on an empty FIFO are dropped
    assign doRead = readRequest && (fill != '0);
    assign doWrite = writeEnable && (fill != (fifoDepthLog2+1)'(depth));

    assign usedw = fill;

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
            readStageValid <= 1'b0;
            dataOutValid <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            readStageValid <= doRead;
            dataOutValid <= readStageValid;
        end
    end

    // RAM read then output register, two cycles from request
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= dataIn;
        end
        if (doRead) begin
            readStage <= mem[rdPtr];
        end
        dataOut <= readStage;
    end

endmodule

`default_nettype wire

// ==== hdl/componentCounter.sv ====
`default_nettype none

module componentCounter (
    input  wire                  clk,
    input  wire                  reset,

    input  wire ccPkg::botEntryT graphIn,
    input  wire                  start,
    output logic                 requestGraph,

    output logic                 done,
    output ccPkg::resultT        result
);

    localparam int numNodes = ccPkg::numNodes;
    localparam int nodeWidth = ccPkg::nodeWidth;

    // Matches the FIFO read path
    localparam int requestLatency = 2;

    typedef enum logic [1:0] {
        stIdle,
        stWaiting,
        stPropagating,
        stCounting
    } stateT;

    stateT state;
    logic [1:0] waitCount;

    logic [numNodes-1:0][numNodes-1:0]  adj;
    logic [numNodes-1:0][numNodes-1:0]  adjNext;
    logic [numNodes-1:0][nodeWidth-1:0] label;
    logic [numNodes-1:0][nodeWidth-1:0] labelNext;
    logic [ccPkg::numEdges-1:0]         edges;
    logic [ccPkg::slotWidth-1:0]        savedSlot;
    ccPkg::countT                       rootCount;

    // Bit position of edge (row, col) with row < col
    function automatic int edgeIndex(input int row, input int col);
        return row * (2 * numNodes - row - 1) / 2 + (col - row - 1);
    endfunction

    assign edges = graphIn.graph[ccPkg::numEdges-1:0];

    // Unfold the triangle into a symmetric matrix
    always_comb begin
        adjNext = '0;
        for (int i = 0; i < numNodes; i++) begin
            for (int j = i + 1; j < numNodes; j++) begin
                adjNext[i][j] = edges[edgeIndex(i, j)];
                adjNext[j][i] = edges[edgeIndex(i, j)];
            end
        end
    end

    // Each node takes the smallest label among itself and its neighbors
    always_comb begin
        labelNext = label;
        for (int i = 0; i < numNodes; i++) begin
            for (int j = 0; j < numNodes; j++) begin
                if (adj[i][j] && (label[j] < labelNext[i])) begin
                    labelNext[i] = label[j];
                end
            end
        end
    end

    // One root per component, isolated nodes skipped
    always_comb begin
        rootCount = '0;
        for (int i = 0; i < numNodes; i++) begin
            if ((|adj[i]) && (label[i] == nodeWidth'(i))) begin
                rootCount = rootCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
            waitCount <= '0;
            requestGraph <= 1'b0;
            done <= 1'b0;
        end else begin
            requestGraph <= 1'b0;
            done <= 1'b0;
            case (state)
                stIdle: begin
                    requestGraph <= 1'b1;
                    waitCount <= '0;
                    state <= stWaiting;
                end
                stWaiting: begin
                    waitCount <= waitCount + 1'b1;
                    if (start) begin
                        state <= stPropagating;
                    end else if (waitCount == 2'(requestLatency)) begin
                        // FIFO was empty, ask again
                        state <= stIdle;
                    end
                end
                stPropagating: begin
                    if (labelNext == label) begin
                        state <= stCounting;
                    end
                end
                stCounting: begin
                    done <= 1'b1;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stWaiting && start) begin
            adj <= adjNext;
            savedSlot <= graphIn.slot;
            for (int i = 0; i < numNodes; i++) begin
                label[i] <= nodeWidth'(i);
            end
        end else if (state == stPropagating) begin
            label <= labelNext;
        end
        if (state == stCounting) begin
            result.count <= rootCount;
            result.slot <= savedSlot;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/streamingComponentCounter.sv ====
`default_nettype none

module streamingComponentCounter #(
    parameter int addrWidth = 9,
    parameter int extraWidth = 1,
    parameter int fifoDepthLog2 = 5,
    parameter int almostFull = 22
) (
    input  wire                   clk,
    input  wire                   reset,

    input  wire                   botValid,
    input  wire ccPkg::graphT     graphIn,
    input  wire [extraWidth-1:0]  extraDataIn,
    output logic                  slowDown,

    output logic                  resultValid,
    output ccPkg::countT          connectCount,
    output logic [extraWidth-1:0] extraDataOut
);

    logic [addrWidth-1:0]   slotIndex;
    logic [fifoDepthLog2:0] usedw;

    ccPkg::botEntryT fifoIn;
    ccPkg::botEntryT fifoOut;
    logic            fifoOutValid;
    logic            readRequest;

    logic            resultDone;
    ccPkg::resultT   result;

    // Slot of the current cycle, results come back when it wraps around
    always_ff @(posedge clk) begin
        if (reset) begin
            slotIndex <= '0;
        end else begin
            slotIndex <= slotIndex + 1'b1;
        end
    end

    assign slowDown = usedw > (fifoDepthLog2+1)'(almostFull);

    assign fifoIn.graph = graphIn;
    assign fifoIn.slot = ccPkg::slotWidth'(slotIndex);

    inputFifo #(
        .fifoDepthLog2(fifoDepthLog2)
    ) inputFifo_i (
        .clk(clk),
        .reset(reset),
        .writeEnable(botValid),
        .dataIn(fifoIn),
        .usedw(usedw),
        .readRequest(readRequest),
        .dataOut(fifoOut),
        .dataOutValid(fifoOutValid)
    );

    componentCounter componentCounter_i (
        .clk(clk),
        .reset(reset),
        .graphIn(fifoOut),
        .start(fifoOutValid),
        .requestGraph(readRequest),
        .done(resultDone),
        .result(result)
    );

    // Counts land at their slot long before the slot is read back
    slotRam #(
        .width(ccPkg::countWidth),
        .addrWidth(addrWidth)
    ) resultRam (
        .clk(clk),
        .writeEnable(resultDone),
        .writeAddr(result.slot[addrWidth-1:0]),
        .dataIn(result.count),
        .readAddr(slotIndex),
        .dataOut(connectCount)
    );

    // Written every cycle so idle slots read back as invalid
    slotRam #(
        .width(1 + extraWidth),
        .addrWidth(addrWidth)
    ) validRam (
        .clk(clk),
        .writeEnable(1'b1),
        .writeAddr(slotIndex),
        .dataIn({botValid, extraDataIn}),
        .readAddr(slotIndex),
        .dataOut({resultValid, extraDataOut})
    );

endmodule

`default_nettype wire

// ==== tests/streamingComponentCounterTb.sv ====
`default_nettype none

module streamingComponentCounterTb;

    localparam int numNodes = ccPkg::numNodes;
    localparam int numRows = 76;
    localparam int slotWindow = 512;
    localparam int watchdogCycles = numRows * 30 + 1200;

    typedef struct {
        ccPkg::graphT graph;
        logic [0:0]   extra;
        int           idleBefore;
        bit           drainBefore;
        bit           resetBefore;
        ccPkg::countT expCount;
    } rowT;

    typedef struct {
        int due;
        bit valid;
        int row;
    } expectT;

    logic         clk = 1'b0;
    logic         reset;
    logic         botValid;
    ccPkg::graphT graphIn;
    logic [0:0]   extraDataIn;
    logic         slowDown;
    logic         resultValid;
    ccPkg::countT connectCount;
    logic [0:0]   extraDataOut;

    rowT    rows [numRows];
    expectT pending [$];
    int     rowDriven;
    int     cycleCount = 0;
    int     outstanding = 0;
    int     errorCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    int     seed = 48270;
    bit     sawSlowDown = 1'b0;

    streamingComponentCounter dut_i (
        .clk(clk),
        .reset(reset),
        .botValid(botValid),
        .graphIn(graphIn),
        .extraDataIn(extraDataIn),
        .slowDown(slowDown),
        .resultValid(resultValid),
        .connectCount(connectCount),
        .extraDataOut(extraDataOut)
    );

    always #50 clk = ~clk;

    // Row-major upper triangle position of edge (i, j), i < j
    function automatic int edgeBit(input int i, input int j);
        int pos;
        pos = 0;
        for (int r = 0; r < i; r++) begin
            pos += numNodes - 1 - r;
        end
        return pos + j - i - 1;
    endfunction

    function automatic ccPkg::graphT withEdge(input ccPkg::graphT g, input int i, input int j);
        g[edgeBit(i, j)] = 1'b1;
        return g;
    endfunction

    // Union-find over all edges, then one root per touched component
    function automatic ccPkg::countT modelCount(input ccPkg::graphT g);
        int parent [numNodes];
        bit touched [numNodes];
        int pos;
        int a;
        int b;
        ccPkg::countT n;
        pos = 0;
        n = '0;
        for (int i = 0; i < numNodes; i++) begin
            parent[i] = i;
            touched[i] = 1'b0;
        end
        for (int i = 0; i < numNodes; i++) begin
            for (int j = i + 1; j < numNodes; j++) begin
                if (g[pos]) begin
                    touched[i] = 1'b1;
                    touched[j] = 1'b1;
                    a = i;
                    while (parent[a] != a) a = parent[a];
                    b = j;
                    while (parent[b] != b) b = parent[b];
                    if (a != b) parent[a] = b;
                end
                pos++;
            end
        end
        for (int i = 0; i < numNodes; i++) begin
            if (touched[i] && parent[i] == i) n++;
        end
        return n;
    endfunction

    // Kind 0 sparse, 1 dense, 2 half density
    function automatic ccPkg::graphT randomGraph(input int kind);
        ccPkg::graphT g;
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w = $random(seed);
            if (kind == 0) begin
                repeat (4) w = w & $random(seed);
            end else if (kind == 1) begin
                w = w | $random(seed);
            end
            g[k*32 +: 32] = w;
        end
        return g;
    endfunction

    task automatic buildTable();
        ccPkg::graphT g;
        // Second burst refills the FIFO past almostFull right before the reset
        for (int r = 0; r < numRows; r++) begin
            rows[r].graph = randomGraph(r % 3);
            rows[r].extra = 1'($random(seed));
            rows[r].idleBefore = (r < 7) ? r : ((r >= 72) ? 3 : 0);
            rows[r].drainBefore = (r == 40);
            rows[r].resetBefore = (r == 72);
            rows[r].expCount = modelCount(rows[r].graph);
        end
        rows[0].graph = '0;
        rows[0].expCount = 0;
        rows[1].graph = withEdge('0, 3, 12);
        rows[1].expCount = 1;
        g = '0;
        for (int k = 0; k < numNodes - 1; k++) g = withEdge(g, k, k + 1);
        rows[2].graph = g;
        rows[2].expCount = 1;
        g = withEdge(withEdge(withEdge('0, 0, 1), 1, 2), 0, 2);
        rows[3].graph = withEdge(withEdge(withEdge(g, 7, 8), 8, 9), 7, 9);
        rows[3].expCount = 2;
        g = '0;
        for (int k = 0; k < 8; k++) g = withEdge(g, k, 15 - k);
        rows[4].graph = g;
        rows[4].expCount = 8;
        rows[5].graph = withEdge(withEdge(withEdge('0, 0, 1), 1, 2), 10, 11);
        rows[5].expCount = 2;
        // Unused top byte set, no edges
        rows[6].graph = {8'hff, 120'b0};
        rows[6].expCount = 0;
        for (int r = 0; r < 7; r++) begin
            if (modelCount(rows[r].graph) != rows[r].expCount) begin
                $display("Model count disagrees with hand-built count for row %0d", r);
                failCount++;
            end
        end
    endtask

    task automatic checkCount(input ccPkg::countT actual, input ccPkg::countT want);
        if (actual !== want) begin
            $display("** Error: connectCount = 0x%0h, expected 0x%0h", actual, want);
            errorCount++;
        end
    endtask

    task automatic checkValid(input logic actual, input logic want);
        if (actual !== want) begin
            $display("** Error: resultValid = 0x%0h, expected 0x%0h", actual, want);
            errorCount++;
        end
    endtask

    task automatic checkExtra(input logic [0:0] actual, input logic [0:0] want);
        if (actual !== want) begin
            $display("** Error: extraDataOut = 0x%0h, expected 0x%0h", actual, want);
            errorCount++;
        end
    endtask

    task automatic driveRow(input int r);
        @(negedge clk);
        while (slowDown) begin
            sawSlowDown = 1'b1;
            @(posedge clk);
            botValid <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        botValid <= 1'b1;
        graphIn <= rows[r].graph;
        extraDataIn <= rows[r].extra;
        rowDriven <= r;
    endtask

    task automatic drainResults();
        @(posedge clk);
        botValid <= 1'b0;
        @(posedge clk);
        while (outstanding != 0) @(posedge clk);
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        botValid <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (slowDown !== 1'b0) begin
            $display("** Error: slowDown = 0x%0h, expected 0x0", slowDown);
            failCount++;
        end
    endtask

    // Records what the DUT samples on each edge
    always @(posedge clk) begin : monitor
        expectT e;
        if (reset) begin
            pending.delete();
            outstanding = 0;
        end else begin
            e.due = cycleCount + slotWindow;
            e.valid = botValid;
            e.row = rowDriven;
            pending.push_back(e);
            if (botValid) outstanding++;
        end
        cycleCount <= cycleCount + 1;
    end

    always @(negedge clk) begin : resultCheck
        expectT e;
        int errorsBefore;
        if (pending.size() != 0 && pending[0].due == cycleCount - 1) begin
            e = pending.pop_front();
            errorsBefore = errorCount;
            checkValid(resultValid, e.valid);
            if (e.valid) begin
                checkCount(connectCount, rows[e.row].expCount);
                checkExtra(extraDataOut, rows[e.row].extra);
                outstanding--;
            end
            if (errorCount != errorsBefore) begin
                failCount++;
            end else if (e.valid) begin
                passCount++;
            end
            if (e.valid) begin
                $display("Row %0d: count %0d, extra %0h, %s", e.row, connectCount,
                         extraDataOut, (errorCount != errorsBefore) ? "mismatch" : "ok");
            end
        end
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: results still outstanding after %0d clock cycles", watchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        reset = 1'b1;
        botValid = 1'b0;
        graphIn = '0;
        extraDataIn = '0;
        rowDriven = 0;
        buildTable();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int r = 0; r < numRows; r++) begin
            if (rows[r].drainBefore) drainResults();
            if (rows[r].resetBefore) applyReset();
            repeat (rows[r].idleBefore) begin
                @(posedge clk);
                botValid <= 1'b0;
            end
            driveRow(r);
        end
        drainResults();
        if (!sawSlowDown) begin
            $display("slowDown never rose during the back-to-back burst");
            failCount++;
        end
        $display("Summary: %0d results passed, %0d failed", passCount, failCount);
        if (failCount == 0 && passCount > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/ccPkg.sv
hdl/slotRam.sv
hdl/inputFifo.sv
hdl/componentCounter.sv
hdl/streamingComponentCounter.sv
tests/streamingComponentCounterTb.sv
